// File: uno_pkg.sv
package uno_pkg;

    typedef enum logic [1:0] {
        COL_RED    = 2'd0,
        COL_YELLOW = 2'd1,
        COL_GREEN  = 2'd2,
        COL_BLUE   = 2'd3
    } card_color_e;

    typedef enum logic [3:0] {
        VAL_0              = 4'd0,
        VAL_1              = 4'd1,
        VAL_2              = 4'd2,
        VAL_3              = 4'd3,
        VAL_4              = 4'd4,
        VAL_5              = 4'd5,
        VAL_6              = 4'd6,
        VAL_7              = 4'd7,
        VAL_8              = 4'd8,
        VAL_9              = 4'd9,
        VAL_SKIP           = 4'd10,
        VAL_REVERSE        = 4'd11,
        VAL_DRAW_TWO       = 4'd12,
        VAL_WILD           = 4'd13,
        VAL_WILD_DRAW_FOUR = 4'd14
    } card_value_e;

    typedef struct packed {
        card_color_e color;                         // declared colour on wilds
        card_value_e value;
    } card_t;

    typedef logic [1:0] seat_t;
    typedef logic [6:0] count_t;

    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_DEAL    = 3'd1,
        ST_FLIP    = 3'd2,
        ST_PLAY    = 3'd3,
        ST_PENALTY = 3'd4,
        ST_END     = 3'd5
    } referee_state_e;

    localparam int NUM_SEATS       = 4;
    localparam int DEAL_SIZE       = 7;
    localparam int DEAL_TOTAL      = NUM_SEATS * DEAL_SIZE;
    localparam int DRAW_TWO_COUNT  = 2;
    localparam int DRAW_FOUR_COUNT = 4;

    localparam int                         DECK_LFSR_WIDTH = 16;
    localparam logic [DECK_LFSR_WIDTH-1:0] DECK_SEED       = 16'hACE1;
    localparam logic [DECK_LFSR_WIDTH-1:0] DECK_TAPS       = 16'hB400;

endpackage

// File: card_source.sv
`timescale 1ns/100ps

module card_source (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_take,
    output uno_pkg::card_t o_card
);

    logic [uno_pkg::DECK_LFSR_WIDTH-1:0] lfsr_r;
    logic [uno_pkg::DECK_LFSR_WIDTH-1:0] lfsr_w;

    // galois step, taps folded in when a one falls out
    assign lfsr_w = lfsr_r[0] ? ((lfsr_r >> 1) ^ uno_pkg::DECK_TAPS) : (lfsr_r >> 1);

    always_comb begin
        o_card.color = uno_pkg::card_color_e'(lfsr_r[5:4]);
        if (lfsr_r[3:0] == 4'hF) begin
            o_card.value = uno_pkg::VAL_0;              // no card with value 15
        end
        else begin
            o_card.value = uno_pkg::card_value_e'(lfsr_r[3:0]);
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            lfsr_r <= uno_pkg::DECK_SEED;               // seed only at reset
        end
        else if (i_take) begin
            lfsr_r <= lfsr_w;
        end
    end

    a_lfsr_nonzero: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        lfsr_r != '0
    );

endmodule

// File: seat_ring.sv
`timescale 1ns/100ps

module seat_ring (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_start_game,
    input  logic           i_advance,
    input  logic           i_double,
    input  logic           i_flip,
    output uno_pkg::seat_t o_seat,
    output logic           o_reversed
);

    uno_pkg::seat_t seat_r, seat_w;
    uno_pkg::seat_t step;
    logic           reversed_r, reversed_w;

    assign reversed_w = reversed_r ^ i_flip;            // flip before stepping
    assign step       = i_double ? 2'd2 : 2'd1;
    assign seat_w     = reversed_w ? (seat_r - step) : (seat_r + step);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_start_game) begin
            seat_r     <= '0;
            reversed_r <= 1'b0;
        end
        else if (i_advance) begin
            seat_r     <= seat_w;
            reversed_r <= reversed_w;
        end
    end

    assign o_seat     = seat_r;
    assign o_reversed = reversed_r;

    a_no_double_flip: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(i_double && i_flip)
    );

endmodule

// File: hand_counts.sv
`timescale 1ns/100ps

module hand_counts (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_clear,
    input  logic            i_add,
    input  logic            i_remove,
    input  uno_pkg::seat_t  i_seat,
    output uno_pkg::count_t o_count [uno_pkg::NUM_SEATS]
);

    uno_pkg::count_t count_r [uno_pkg::NUM_SEATS];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_clear) begin
            for (int i = 0; i < uno_pkg::NUM_SEATS; i++) begin
                count_r[i] <= '0;
            end
        end
        else if (i_add) begin
            count_r[i_seat] <= count_r[i_seat] + 7'd1;   // dealt or drawn
        end
        else if (i_remove) begin
            count_r[i_seat] <= count_r[i_seat] - 7'd1;   // played
        end
    end

    assign o_count = count_r;

    a_no_underflow: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_remove && !i_add && !i_clear) |-> (count_r[i_seat] != '0)
    );

    a_no_overflow: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_add && !i_clear) |-> (count_r[i_seat] != '1)
    );

endmodule

// File: uno_referee.sv
`timescale 1ns/100ps

module uno_referee (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_start,
    input  logic            i_cyc,
    input  logic            i_stb,
    input  logic            i_we,
    input  uno_pkg::card_t  i_dat,
    input  uno_pkg::card_t  i_card,
    input  uno_pkg::seat_t  i_seat,
    input  logic            i_reversed,
    input  uno_pkg::count_t i_count [uno_pkg::NUM_SEATS],
    output logic            o_ack,
    output logic            o_err,
    output uno_pkg::card_t  o_dat,
    output logic            o_take,
    output logic            o_clear,
    output logic            o_add,
    output logic            o_remove,
    output uno_pkg::seat_t  o_count_seat,
    output logic            o_start_game,
    output logic            o_advance,
    output logic            o_double,
    output logic            o_flip,
    output uno_pkg::card_t  o_top_card,
    output logic            o_busy,
    output logic            o_end,
    output uno_pkg::seat_t  o_winner
);

    uno_pkg::referee_state_e state_r, state_w;
    logic [4:0]              deal_cnt_r, deal_cnt_w;
    logic [2:0]              pen_cnt_r, pen_cnt_w;
    logic                    ack_r, ack_w;
    logic                    err_r, err_w;
    uno_pkg::card_t          top_card_r, top_card_w;
    uno_pkg::card_t          dat_r, dat_w;
    uno_pkg::seat_t          winner_r, winner_w;
    logic                    req;
    logic                    legal;

    // one answer per strobe, the pulse blocks a second sample
    assign req   = (state_r == uno_pkg::ST_PLAY) && i_cyc && i_stb && !ack_r && !err_r;
    assign legal = (i_dat.value == uno_pkg::VAL_WILD)
                || (i_dat.value == uno_pkg::VAL_WILD_DRAW_FOUR)
                || (i_dat.color == top_card_r.color)
                || (i_dat.value == top_card_r.value);

    always_comb begin
        state_w      = state_r;
        deal_cnt_w   = deal_cnt_r;
        pen_cnt_w    = pen_cnt_r;
        top_card_w   = top_card_r;
        dat_w        = dat_r;
        winner_w     = winner_r;
        ack_w        = 1'b0;
        err_w        = 1'b0;
        o_take       = 1'b0;
        o_clear      = 1'b0;
        o_add        = 1'b0;
        o_remove     = 1'b0;
        o_count_seat = i_seat;
        o_start_game = 1'b0;
        o_advance    = 1'b0;
        o_double     = 1'b0;
        o_flip       = 1'b0;
        case (state_r)
            uno_pkg::ST_IDLE: begin
                if (i_start) begin
                    state_w      = uno_pkg::ST_DEAL;
                    deal_cnt_w   = '0;
                    o_clear      = 1'b1;
                    o_start_game = 1'b1;
                end
            end
            uno_pkg::ST_DEAL: begin
                o_take       = 1'b1;
                o_add        = 1'b1;
                o_count_seat = deal_cnt_r[1:0];              // round robin over seats
                deal_cnt_w   = deal_cnt_r + 5'd1;
                if (deal_cnt_r == 5'(uno_pkg::DEAL_TOTAL - 1)) begin
                    state_w = uno_pkg::ST_FLIP;
                end
            end
            uno_pkg::ST_FLIP: begin
                o_take     = 1'b1;
                top_card_w = i_card;
                state_w    = uno_pkg::ST_PLAY;
            end
            uno_pkg::ST_PLAY: begin
                if (req && !i_we) begin
                    ack_w     = 1'b1;
                    o_take    = 1'b1;
                    o_add     = 1'b1;
                    o_advance = 1'b1;
                    dat_w     = i_card;                      // card leaving the deck
                end
                else if (req && !legal) begin
                    err_w = 1'b1;
                end
                else if (req) begin
                    ack_w      = 1'b1;
                    o_remove   = 1'b1;
                    top_card_w = i_dat;
                    if (i_count[i_seat] == 7'd1) begin
                        state_w  = uno_pkg::ST_END;
                        winner_w = i_seat;
                    end
                    else begin
                        o_advance = 1'b1;
                        case (i_dat.value)
                            uno_pkg::VAL_SKIP: begin
                                o_double = 1'b1;
                            end
                            uno_pkg::VAL_REVERSE: begin
                                o_flip = 1'b1;
                            end
                            uno_pkg::VAL_DRAW_TWO: begin
                                state_w   = uno_pkg::ST_PENALTY;  // ring lands on victim
                                pen_cnt_w = 3'(uno_pkg::DRAW_TWO_COUNT);
                            end
                            uno_pkg::VAL_WILD_DRAW_FOUR: begin
                                state_w   = uno_pkg::ST_PENALTY;
                                pen_cnt_w = 3'(uno_pkg::DRAW_FOUR_COUNT);
                            end
                            default: begin
                            end
                        endcase
                    end
                end
            end
            uno_pkg::ST_PENALTY: begin
                o_take    = 1'b1;
                o_add     = 1'b1;
                pen_cnt_w = pen_cnt_r - 3'd1;
                if (pen_cnt_r == 3'd1) begin
                    o_advance = 1'b1;                        // victim loses the turn
                    state_w   = uno_pkg::ST_PLAY;
                end
            end
            uno_pkg::ST_END: begin
                if (!i_start) begin
                    state_w = uno_pkg::ST_IDLE;
                end
            end
            default: begin
                state_w = uno_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r    <= uno_pkg::ST_IDLE;
            deal_cnt_r <= '0;
            pen_cnt_r  <= '0;
            ack_r      <= 1'b0;
            err_r      <= 1'b0;
        end
        else begin
            state_r    <= state_w;
            deal_cnt_r <= deal_cnt_w;
            pen_cnt_r  <= pen_cnt_w;
            ack_r      <= ack_w;
            err_r      <= err_w;
        end
    end

    always_ff @(posedge i_clk) begin
        top_card_r <= top_card_w;
        dat_r      <= dat_w;
        winner_r   <= winner_w;
    end

    assign o_ack      = ack_r;
    assign o_err      = err_r;
    assign o_dat      = dat_r;
    assign o_top_card = top_card_r;
    assign o_winner   = winner_r;
    assign o_end      = (state_r == uno_pkg::ST_END);
    assign o_busy     = (state_r == uno_pkg::ST_DEAL) || (state_r == uno_pkg::ST_FLIP)
                     || (state_r == uno_pkg::ST_PENALTY);

    a_ack_err_excl: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !(o_ack && o_err)
    );

    a_reply_needs_stb: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (o_ack || o_err) |-> ($past(i_cyc && i_stb) && i_stb)
    );

endmodule

// File: uno_top.sv
`timescale 1ns/100ps

module uno_top (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_start,
    input  logic            i_cyc,
    input  logic            i_stb,
    input  logic            i_we,
    input  uno_pkg::card_t  i_dat,
    output logic            o_ack,
    output logic            o_err,
    output uno_pkg::card_t  o_dat,
    output uno_pkg::seat_t  o_seat,
    output logic            o_reversed,
    output uno_pkg::card_t  o_top_card,
    output uno_pkg::count_t o_hand_count [uno_pkg::NUM_SEATS],
    output logic            o_busy,
    output logic            o_end,
    output uno_pkg::seat_t  o_winner
);

    uno_pkg::card_t  card;
    uno_pkg::seat_t  seat;
    uno_pkg::seat_t  count_seat;
    uno_pkg::count_t count [uno_pkg::NUM_SEATS];
    logic            reversed;
    logic            take, clear, add, remove;
    logic            start_game, advance, double_step, flip;

    card_source u_card_source (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_take  (take),
        .o_card  (card)
    );

    seat_ring u_seat_ring (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start_game (start_game),
        .i_advance    (advance),
        .i_double     (double_step),
        .i_flip       (flip),
        .o_seat       (seat),
        .o_reversed   (reversed)
    );

    hand_counts u_hand_counts (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_clear  (clear),
        .i_add    (add),
        .i_remove (remove),
        .i_seat   (count_seat),
        .o_count  (count)
    );

    uno_referee u_referee (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_cyc        (i_cyc),
        .i_stb        (i_stb),
        .i_we         (i_we),
        .i_dat        (i_dat),
        .i_card       (card),
        .i_seat       (seat),
        .i_reversed   (reversed),
        .i_count      (count),
        .o_ack        (o_ack),
        .o_err        (o_err),
        .o_dat        (o_dat),
        .o_take       (take),
        .o_clear      (clear),
        .o_add        (add),
        .o_remove     (remove),
        .o_count_seat (count_seat),
        .o_start_game (start_game),
        .o_advance    (advance),
        .o_double     (double_step),
        .o_flip       (flip),
        .o_top_card   (o_top_card),
        .o_busy       (o_busy),
        .o_end        (o_end),
        .o_winner     (o_winner)
    );

    assign o_seat       = seat;
    assign o_reversed   = reversed;
    assign o_hand_count = count;

endmodule

// File: tb_uno_model.svh
logic [15:0]     m_lfsr;
uno_pkg::seat_t  m_seat;
logic            m_rev;
uno_pkg::count_t m_count [uno_pkg::NUM_SEATS];
uno_pkg::card_t  m_top;
logic            m_end;
uno_pkg::seat_t  m_winner;

function automatic uno_pkg::card_t card_of(logic [15:0] s);
    uno_pkg::card_t c;
    c.color = uno_pkg::card_color_e'(s[5:4]);
    c.value = (s[3:0] == 4'hF) ? uno_pkg::VAL_0 : uno_pkg::card_value_e'(s[3:0]);
    return c;
endfunction

function automatic uno_pkg::seat_t next_seat(uno_pkg::seat_t s, logic rev, int n);
    int k;
    k = rev ? (int'(s) - n + uno_pkg::NUM_SEATS) : (int'(s) + n);
    return uno_pkg::seat_t'(k % uno_pkg::NUM_SEATS);
endfunction

function automatic logic is_legal(uno_pkg::card_t c);
    return (c.value == uno_pkg::VAL_WILD) || (c.value == uno_pkg::VAL_WILD_DRAW_FOUR)
        || (c.color == m_top.color) || (c.value == m_top.value);
endfunction

task automatic reset_model();
    m_lfsr = uno_pkg::DECK_SEED;                    // deck restarts only at reset
    m_seat = '0;
    m_rev  = 1'b0;
    m_end  = 1'b0;
    for (int i = 0; i < uno_pkg::NUM_SEATS; i++) begin
        m_count[i] = '0;
    end
endtask

task automatic take_card(output uno_pkg::card_t c);
    c      = card_of(m_lfsr);
    m_lfsr = m_lfsr[0] ? ((m_lfsr >> 1) ^ uno_pkg::DECK_TAPS) : (m_lfsr >> 1);
endtask

task automatic deal_cards();
    uno_pkg::card_t c;
    for (int i = 0; i < uno_pkg::NUM_SEATS * uno_pkg::DEAL_SIZE; i++) begin
        take_card(c);
        m_count[i % uno_pkg::NUM_SEATS] = m_count[i % uno_pkg::NUM_SEATS] + 7'd1;
    end
    take_card(m_top);                               // 29th card turned over
    m_seat = '0;
    m_rev  = 1'b0;
endtask

task automatic draw_card(output uno_pkg::card_t c);
    take_card(c);
    m_count[m_seat] = m_count[m_seat] + 7'd1;
    m_seat          = next_seat(m_seat, m_rev, 1);
endtask

task automatic play_card(input uno_pkg::card_t c, output int penalty);
    penalty         = 0;
    m_top           = c;
    m_end           = (m_count[m_seat] == 7'd1);
    m_winner        = m_seat;
    m_count[m_seat] = m_count[m_seat] - 7'd1;
    if (!m_end) begin
        case (c.value)
            uno_pkg::VAL_SKIP: m_seat = next_seat(m_seat, m_rev, 2);
            uno_pkg::VAL_REVERSE: begin
                m_rev  = !m_rev;
                m_seat = next_seat(m_seat, m_rev, 1);
            end
            uno_pkg::VAL_DRAW_TWO: begin
                m_seat  = next_seat(m_seat, m_rev, 1);   // victim
                penalty = uno_pkg::DRAW_TWO_COUNT;
            end
            uno_pkg::VAL_WILD_DRAW_FOUR: begin
                m_seat  = next_seat(m_seat, m_rev, 1);
                penalty = uno_pkg::DRAW_FOUR_COUNT;
            end
            default: m_seat = next_seat(m_seat, m_rev, 1);
        endcase
    end
endtask

task automatic penalise(input int n);
    uno_pkg::card_t c;
    for (int i = 0; i < n; i++) begin
        take_card(c);
        m_count[m_seat] = m_count[m_seat] + 7'd1;
    end
    m_seat = next_seat(m_seat, m_rev, 1);           // victim loses the turn
endtask

// File: tb_uno.sv
`timescale 1ns/100ps

module tb_uno;

    localparam int NUM_GAMES      = 3;
    localparam int MAX_MOVES      = 300;
    localparam int TIMEOUT_CYCLES = NUM_GAMES * (30 + MAX_MOVES * 8) + 1000;

    logic            i_clk;
    logic            i_rst_n;
    logic            i_start;
    logic            i_cyc;
    logic            i_stb;
    logic            i_we;
    uno_pkg::card_t  i_dat;
    logic            o_ack;
    logic            o_err;
    uno_pkg::card_t  o_dat;
    uno_pkg::seat_t  o_seat;
    logic            o_reversed;
    uno_pkg::card_t  o_top_card;
    uno_pkg::count_t o_hand_count [uno_pkg::NUM_SEATS];
    logic            o_busy;
    logic            o_end;
    uno_pkg::seat_t  o_winner;
    logic [31:0]     rng_state;
    int              cycles = 0;

    `include "tb_uno_model.svh"

    uno_top dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("timeout: game did not finish");
            abort_run();
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic card_check(input string name, input uno_pkg::card_t exp,
                              input uno_pkg::card_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic seat_check(input string name, input uno_pkg::seat_t exp,
                              input uno_pkg::seat_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic count_check(input string name, input uno_pkg::count_t exp,
                               input uno_pkg::count_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic flag_check(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            rng_state = lfsr_step(rng_state);
            bits      = {bits[6:0], rng_state[0]};    // one step per bit
        end
    endtask

    task automatic pick_legal(output uno_pkg::card_t c);
        logic [7:0] kind;
        logic [7:0] col;
        logic [7:0] val;
        take_bits(2, kind);
        take_bits(2, col);
        take_bits(4, val);
        c.color = uno_pkg::card_color_e'(col[1:0]);
        c.value = uno_pkg::card_value_e'(val[3:0] % 4'd13);
        if (kind[1:0] == 2'd1) begin
            c.value = m_top.value;                  // match on value
        end
        else if (kind[1:0] == 2'd2) begin
            c.value = (val[1:0] == 2'b11) ? uno_pkg::VAL_WILD_DRAW_FOUR : uno_pkg::VAL_WILD;
        end
        else begin
            c.color = m_top.color;
        end
    endtask

    task automatic make_illegal(output uno_pkg::card_t c);
        logic [7:0] val;
        logic [3:0] v;
        logic [1:0] col;
        take_bits(4, val);
        v   = val[3:0] % 4'd13;
        col = m_top.color + 2'd1;
        if (v == m_top.value) begin
            v = (v + 4'd1) % 4'd13;
        end
        c.color = uno_pkg::card_color_e'(col);
        c.value = uno_pkg::card_value_e'(v);
    endtask

    task automatic status_check(input string name);
        seat_check({name, " seat"}, m_seat, o_seat);
        flag_check({name, " reversed"}, m_rev, o_reversed);
        flag_check({name, " end"}, m_end, o_end);
        flag_check({name, " busy"}, 1'b0, o_busy);
        for (int i = 0; i < uno_pkg::NUM_SEATS; i++) begin
            count_check($sformatf("%s count %0d", name, i), m_count[i], o_hand_count[i]);
        end
    endtask

    task automatic state_check(input string name);
        card_check({name, " top card"}, m_top, o_top_card);
        status_check(name);
    endtask

    task automatic hold_reset();
        @(negedge i_clk);
        i_rst_n = 1'b0;
        i_start = 1'b0;
        repeat (8) @(negedge i_clk);
        i_rst_n = 1'b1;
        reset_model();
        flag_check("reset ack", 1'b0, o_ack);
        flag_check("reset err", 1'b0, o_err);
        status_check("reset");
    endtask

    task automatic start_game();
        @(negedge i_clk);
        i_start = 1'b1;
        @(negedge i_clk);
        while (o_busy) @(negedge i_clk);             // deal and flip
        deal_cards();
        state_check("deal");
    endtask

    task automatic drive_move(input logic we, input uno_pkg::card_t c, output logic ack,
                              output logic err, output uno_pkg::card_t dat);
        i_cyc = 1'b1;
        i_stb = 1'b1;
        i_we  = we;
        i_dat = c;
        @(negedge i_clk);
        while (!o_ack && !o_err) @(negedge i_clk);
        ack = o_ack;
        err = o_err;
        dat = o_dat;
        @(negedge i_clk);                           // hold stb through the reply
        i_cyc = 1'b0;
        i_stb = 1'b0;
    endtask

    task automatic run_one_move();
        logic [7:0]     pick;
        uno_pkg::card_t c;
        uno_pkg::card_t got;
        logic           ack;
        logic           err;
        int             pen;
        @(negedge i_clk);
        take_bits(3, pick);
        if (pick[2:0] == 3'd0) begin
            drive_move(1'b0, '0, ack, err, got);
            draw_card(c);
            flag_check("draw ack", 1'b1, ack);
            card_check("draw card", c, got);
        end
        else begin
            if (pick[2:0] == 3'd1) begin
                make_illegal(c);
            end
            else begin
                pick_legal(c);
            end
            drive_move(1'b1, c, ack, err, got);
            flag_check("play ack", is_legal(c), ack);
            flag_check("play err", !is_legal(c), err);
            if (is_legal(c)) begin
                play_card(c, pen);
                if (pen > 0) begin
                    while (o_busy) @(negedge i_clk);
                    penalise(pen);
                end
            end
        end
        state_check("move");
    endtask

    task automatic finish_game();
        seat_check("winner", m_winner, o_winner);
        @(negedge i_clk);
        i_start = 1'b0;
        @(negedge i_clk);
        flag_check("end after start low", 1'b0, o_end);
        flag_check("busy after start low", 1'b0, o_busy);
    endtask

    task automatic play_game();
        int moves;
        hold_reset();
        start_game();
        moves = 0;
        while (moves < MAX_MOVES && !m_end) begin
            run_one_move();
            moves++;
        end
        if (m_end) begin
            finish_game();
        end
    endtask

    initial begin
        i_rst_n   = 1'b0;
        i_start   = 1'b0;
        i_cyc     = 1'b0;
        i_stb     = 1'b0;
        i_we      = 1'b0;
        i_dat     = '0;
        rng_state = 32'd24;
        for (int g = 0; g < NUM_GAMES; g++) begin
            play_game();
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
uno_pkg.sv
card_source.sv
seat_ring.sv
hand_counts.sv
uno_referee.sv
uno_top.sv
tb_uno.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_uno -f verilog.f -o tb_uno_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi
./obj_dir/tb_uno_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
